// File: sim/ecg_feature_testdata.txt
// in: mode lead rr_pre rr_post q_loc s_loc r_loc t_loc st_loc r q s p t st st2 st4 st6 iso
// out: rr_diff qrs 8 deviations, 5 mi features, 5 mi sums, init_features_end
// multi-lead beat, leads 0 to 11, st slope branches
1 0 c8 cc 64 6e 78 96 a0 320 ff88 fed4 3c fa 1e 28 2f 1b 0
4 a 0 0 0 0 0 0 0 0 ff88 fed4 fa 28 fffc ff88 fed4 fa 28 fffc 0
1 1 c8 cc 64 6e 78 96 9e 320 ff88 fed4 3c fa 1e 28 2f 1b 1
4 a 0 0 0 0 0 0 0 0 ff87 fed3 f9 27 fffc ff0f fda7 1f3 4f fff8 0
1 2 c8 cc 64 6e 78 96 9d 320 ff88 fed4 3c fa 1e 28 2f 1b 2
4 a 0 0 0 0 0 0 0 0 ff86 fed2 f8 26 3 fe95 fc79 2eb 75 fffb 0
1 3 c8 cc 64 6e 78 96 9a 320 ff88 fed4 3c fa 1e 28 2f 1b 3
4 a 0 0 0 0 0 0 0 0 ff85 fed1 f7 25 3 fe1a fb4a 3e2 9a fffe 0
1 4 c8 cc 64 6e 78 96 99 320 ff88 fed4 3c fa 1e 28 2f 1b 4
4 a 0 0 0 0 0 0 0 0 ff84 fed0 f6 24 a fd9e fa1a 4d8 be 8 0
1 5 c8 cc 64 6e 78 96 91 320 ff88 fed4 3c fa 1e 28 2f 1b 5
4 a 0 0 0 0 0 0 0 0 ff83 fecf f5 23 a fd21 f8e9 5cd e1 12 0
1 6 c8 cc 64 6e 78 ff a0 320 ff88 fed4 3c fa 1e 28 2f 1b 6
4 a 0 0 0 0 0 0 0 0 ff82 fece f4 22 0 fca3 f7b7 6c1 103 12 0
1 7 c8 cc 64 6e ff 96 a0 320 ff88 fed4 3c fa 1e 28 2f 1b 7
4 a 0 0 0 0 0 0 0 0 ff81 fecd f3 21 0 fc24 f684 7b4 124 12 0
1 8 c8 cc 64 6e 78 96 a2 320 ff88 fed4 3c fa 1e 28 2f 1b 8
4 a 0 0 0 0 0 0 0 0 ff80 fecc f2 20 fffc fba4 f550 8a6 144 e 0
1 9 c8 cc 64 6e 78 96 96 320 ff88 fed4 3c fa 1e 28 2f 1b 9
4 a 0 0 0 0 0 0 0 0 ff7f fecb f1 1f a fb23 f41b 997 163 18 0
1 a c8 cc 64 6e 78 96 9c 320 ff88 fed4 3c fa 1e 28 2f 1b a
4 a 0 0 0 0 0 0 0 0 ff7e feca f0 1e 3 faa1 f2e5 a87 181 1b 0
1 b c8 cc 64 6e 78 96 9f 320 ff88 fed4 3c fa 1e 28 2f 1b b
4 a 0 0 0 0 0 0 0 0 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 0
// single-lead beats two to eight, averages still filling
0 0 ca c8 64 70 78 96 a0 320 ff88 feca 3c fa 1e 28 2f 1b 0
fffe c 0 0 0 0 0 0 0 0 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 0
0 0 c6 c6 64 6c 78 96 a0 320 ff88 fede 3c fa 1e 28 2f 1b 0
0 8 0 0 0 0 0 0 0 0 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 0
0 0 cc d2 64 6e 78 96 a0 320 ff88 fed4 3c fa 1e 28 2f 1b 0
6 a 0 0 0 0 0 0 0 0 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 0
0 0 c4 c4 64 6e 78 96 a0 320 ff88 fecf 3c fa 1e 28 2f 1b 0
0 a 0 0 0 0 0 0 0 0 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 0
0 0 c8 c6 64 72 78 96 a0 320 ff88 fed9 3c fa 1e 28 2f 1b 0
fffe e 0 0 0 0 0 0 0 0 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 0
0 0 ce ce 64 6a 78 96 a0 320 ff88 fed4 3c fa 1e 28 2f 1b 0
0 6 0 0 0 0 0 0 0 0 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 0
0 0 c2 be 64 6e 78 96 a0 320 ff88 fed3 3c fa 1e 28 2f 1b 0
fffc a 0 0 0 0 0 0 0 0 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 1
// deviations from the frozen averages
0 0 d2 be 64 73 78 96 a0 334 ff9c feca 32 10e 1e 28 2f 1b 0
ffec f a fff6 5 14 14 fff7 fff6 14 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 1
0 0 be cd 62 6a 78 96 a0 30c ff7e fed9 40 f0 1e 28 2f 1b 0
f 8 fff6 5 fffe ffec fff6 6 4 fff6 ff7d fec9 ef 1d fffc fa1e f1ae b76 19e 17 1
// new multi-lead beat, lead 0 restarts the mi sums
1 0 be cd 62 6a 78 96 9a 30c ff7e fed9 40 f0 1e 28 2f 1b 5
f 8 fff6 5 fffe ffec fff6 6 4 fff6 ff79 fed4 eb 23 3 ff79 fed4 eb 23 3 1

// File: project.f
+incdir+include
src/ecg_feature_pkg.sv
src/feature_sequencer.sv
src/beat_average.sv
src/st_morphology.sv
src/ecg_feature_top.sv
sim/tb_ecg_feature.sv

// File: Bender.yml
package:
  name: ecg_feature

export_include_dirs:
  - include

sources:
  - files:
      - src/ecg_feature_pkg.sv
      - src/feature_sequencer.sv
      - src/beat_average.sv
      - src/st_morphology.sv
      - src/ecg_feature_top.sv
  - target: test
    files:
      - sim/tb_ecg_feature.sv

// File: sim/tb_ecg_feature.sv
`timescale 1ns/1ps
`default_nettype none

`include "feature_defines.svh"

module tb_ecg_feature
    import ecg_feature_pkg::*;
();

    localparam int NUM_EVENTS = 22;
    localparam int IN_WORDS   = 19;
    localparam int EXP_WORDS  = 21;
    localparam int ROW_WORDS  = IN_WORDS + EXP_WORDS;
    localparam int TIMEOUT    = 20;

    logic                    wclk;
    logic                    rst_n;
    logic                    feature_rdy;
    logic                    mode;
    logic [`FEA_LEAD_DW-1:0] cnt_lead;
    interval_t               rr_pre;
    interval_t               rr_post;
    interval_t               q_loc;
    interval_t               s_loc;
    interval_t               r_loc;
    interval_t               t_loc;
    interval_t               st_loc;
    amp_t                    r_amp;
    amp_t                    q_amp;
    amp_t                    s_amp;
    amp_t                    p_amp;
    amp_t                    t_amp;
    amp_t                    st_amp;
    amp_t                    st_amp_2;
    amp_t                    st_amp_4;
    amp_t                    st_amp_6;
    amp_t                    iso_line;
    interval_t               rr_diff;
    interval_t               qrs;
    interval_t               rr_pre_rr_ave;
    interval_t               rr_post_rr_ave;
    interval_t               qrs_cur_qrs_ave;
    amp_t                    r_amp_r_amp_ave;
    amp_t                    q_amp_q_amp_ave;
    amp_t                    s_amp_s_amp_ave;
    amp_t                    p_amp_p_amp_ave;
    amp_t                    t_amp_t_amp_ave;
    amp_t                    q_amp_iso;
    amp_t                    s_amp_iso;
    amp_t                    t_amp_iso;
    amp_t                    st_amp_iso;
    amp_t                    st_slo;
    feat_sum_t               q_amp_iso_sum;
    feat_sum_t               s_amp_iso_sum;
    feat_sum_t               t_amp_iso_sum;
    feat_sum_t               st_amp_iso_sum;
    feat_sum_t               st_slo_sum;
    logic                    feature_done;
    logic                    init_features_end;

    // one row per event, inputs then expected outputs
    logic [15:0] vec [0:NUM_EVENTS*ROW_WORDS-1];

    ecg_feature_top ecg_feature_top_i (
        .wclk(wclk), .rst_n(rst_n), .feature_rdy(feature_rdy), .mode(mode),
        .cnt_lead(cnt_lead), .rr_pre(rr_pre), .rr_post(rr_post), .q_loc(q_loc),
        .s_loc(s_loc), .r_loc(r_loc), .t_loc(t_loc), .st_loc(st_loc),
        .r_amp(r_amp), .q_amp(q_amp), .s_amp(s_amp), .p_amp(p_amp), .t_amp(t_amp),
        .st_amp(st_amp), .st_amp_2(st_amp_2), .st_amp_4(st_amp_4),
        .st_amp_6(st_amp_6), .iso_line(iso_line),
        .rr_diff(rr_diff), .qrs(qrs), .rr_pre_rr_ave(rr_pre_rr_ave),
        .rr_post_rr_ave(rr_post_rr_ave), .qrs_cur_qrs_ave(qrs_cur_qrs_ave),
        .r_amp_r_amp_ave(r_amp_r_amp_ave), .q_amp_q_amp_ave(q_amp_q_amp_ave),
        .s_amp_s_amp_ave(s_amp_s_amp_ave), .p_amp_p_amp_ave(p_amp_p_amp_ave),
        .t_amp_t_amp_ave(t_amp_t_amp_ave), .q_amp_iso(q_amp_iso),
        .s_amp_iso(s_amp_iso), .t_amp_iso(t_amp_iso), .st_amp_iso(st_amp_iso),
        .st_slo(st_slo), .q_amp_iso_sum(q_amp_iso_sum), .s_amp_iso_sum(s_amp_iso_sum),
        .t_amp_iso_sum(t_amp_iso_sum), .st_amp_iso_sum(st_amp_iso_sum),
        .st_slo_sum(st_slo_sum), .feature_done(feature_done),
        .init_features_end(init_features_end)
    );

    always #4 wclk = ~wclk;

    function automatic string output_name(input int idx);
        case (idx)
            0:  return "rr_diff";
            1:  return "qrs";
            2:  return "rr_pre_rr_ave";
            3:  return "rr_post_rr_ave";
            4:  return "qrs_cur_qrs_ave";
            5:  return "r_amp_r_amp_ave";
            6:  return "q_amp_q_amp_ave";
            7:  return "s_amp_s_amp_ave";
            8:  return "p_amp_p_amp_ave";
            9:  return "t_amp_t_amp_ave";
            10: return "q_amp_iso";
            11: return "s_amp_iso";
            12: return "t_amp_iso";
            13: return "st_amp_iso";
            14: return "st_slo";
            15: return "q_amp_iso_sum";
            16: return "s_amp_iso_sum";
            17: return "t_amp_iso_sum";
            18: return "st_amp_iso_sum";
            19: return "st_slo_sum";
            default: return "init_features_end";
        endcase
    endfunction

    // sign extended to the width of the data file words
    function automatic feat_sum_t output_value(input int idx);
        case (idx)
            0:  return feat_sum_t'(rr_diff);
            1:  return feat_sum_t'(qrs);
            2:  return feat_sum_t'(rr_pre_rr_ave);
            3:  return feat_sum_t'(rr_post_rr_ave);
            4:  return feat_sum_t'(qrs_cur_qrs_ave);
            5:  return feat_sum_t'(r_amp_r_amp_ave);
            6:  return feat_sum_t'(q_amp_q_amp_ave);
            7:  return feat_sum_t'(s_amp_s_amp_ave);
            8:  return feat_sum_t'(p_amp_p_amp_ave);
            9:  return feat_sum_t'(t_amp_t_amp_ave);
            10: return feat_sum_t'(q_amp_iso);
            11: return feat_sum_t'(s_amp_iso);
            12: return feat_sum_t'(t_amp_iso);
            13: return feat_sum_t'(st_amp_iso);
            14: return feat_sum_t'(st_slo);
            15: return q_amp_iso_sum;
            16: return s_amp_iso_sum;
            17: return t_amp_iso_sum;
            18: return st_amp_iso_sum;
            19: return st_slo_sum;
            default: return {15'b0, init_features_end};
        endcase
    endfunction

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic apply_inputs(input int base);
        mode     = vec[base][0];
        cnt_lead = vec[base+1][`FEA_LEAD_DW-1:0];
        rr_pre   = vec[base+2][`FEA_INTERVAL_DW-1:0];
        rr_post  = vec[base+3][`FEA_INTERVAL_DW-1:0];
        q_loc    = vec[base+4][`FEA_INTERVAL_DW-1:0];
        s_loc    = vec[base+5][`FEA_INTERVAL_DW-1:0];
        r_loc    = vec[base+6][`FEA_INTERVAL_DW-1:0];
        t_loc    = vec[base+7][`FEA_INTERVAL_DW-1:0];
        st_loc   = vec[base+8][`FEA_INTERVAL_DW-1:0];
        r_amp    = vec[base+9][`FEA_INPUT_DW-1:0];
        q_amp    = vec[base+10][`FEA_INPUT_DW-1:0];
        s_amp    = vec[base+11][`FEA_INPUT_DW-1:0];
        p_amp    = vec[base+12][`FEA_INPUT_DW-1:0];
        t_amp    = vec[base+13][`FEA_INPUT_DW-1:0];
        st_amp   = vec[base+14][`FEA_INPUT_DW-1:0];
        st_amp_2 = vec[base+15][`FEA_INPUT_DW-1:0];
        st_amp_4 = vec[base+16][`FEA_INPUT_DW-1:0];
        st_amp_6 = vec[base+17][`FEA_INPUT_DW-1:0];
        iso_line = vec[base+18][`FEA_INPUT_DW-1:0];
    endtask

    task automatic run_event(input int ev);
        int base;
        int cycles;
        base = ev * ROW_WORDS;
        apply_inputs(base);
        feature_rdy = 1'b1;
        @(negedge wclk);
        feature_rdy = 1'b0;
        cycles = 1;
        while (!feature_done && cycles < TIMEOUT) begin
            @(negedge wclk);
            cycles++;
        end
        if (!feature_done) begin
            $display("feature_done never arrived for event %0d", ev);
            $display("Checks failed");
            $fatal(1, "timeout waiting for feature_done");
        end
        check($sformatf("event %0d latency", ev), 16'd4, 16'(cycles));
        // outputs and beat count settle one cycle after the done pulse
        @(negedge wclk);
        check($sformatf("event %0d done pulse width", ev), 16'd0, {15'b0, feature_done});
        for (int i = 0; i < EXP_WORDS; i++) begin
            check($sformatf("event %0d %s", ev, output_name(i)),
                  vec[base+IN_WORDS+i], output_value(i));
        end
    endtask

    initial begin
        wclk        = 1'b0;
        rst_n       = 1'b0;
        feature_rdy = 1'b0;
        mode        = 1'b0;
        cnt_lead    = '0;
        {rr_pre, rr_post, q_loc, s_loc, r_loc, t_loc, st_loc} = '0;
        {r_amp, q_amp, s_amp, p_amp, t_amp} = '0;
        {st_amp, st_amp_2, st_amp_4, st_amp_6, iso_line} = '0;
        $readmemh("sim/ecg_feature_testdata.txt", vec);
        repeat (4) @(posedge wclk);
        @(negedge wclk);
        rst_n = 1'b1;
        @(negedge wclk);
        check("reset feature_done", 16'd0, {15'b0, feature_done});
        for (int i = 0; i < EXP_WORDS; i++) begin
            check($sformatf("reset %s", output_name(i)), 16'd0, output_value(i));
        end
        for (int ev = 0; ev < NUM_EVENTS; ev++) begin
            run_event(ev);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/ecg_feature_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "feature_defines.svh"

module ecg_feature_top
    import ecg_feature_pkg::*;
(
    input  wire                    wclk,
    input  wire                    rst_n,
    input  wire                    feature_rdy,
    input  wire                    mode,
    input  wire [`FEA_LEAD_DW-1:0] cnt_lead,
    input  wire interval_t         rr_pre,
    input  wire interval_t         rr_post,
    input  wire interval_t         q_loc,
    input  wire interval_t         s_loc,
    input  wire interval_t         r_loc,
    input  wire interval_t         t_loc,
    input  wire interval_t         st_loc,
    input  wire amp_t              r_amp,
    input  wire amp_t              q_amp,
    input  wire amp_t              s_amp,
    input  wire amp_t              p_amp,
    input  wire amp_t              t_amp,
    input  wire amp_t              st_amp,
    input  wire amp_t              st_amp_2,
    input  wire amp_t              st_amp_4,
    input  wire amp_t              st_amp_6,
    input  wire amp_t              iso_line,
    output interval_t              rr_diff,
    output interval_t              qrs,
    output interval_t              rr_pre_rr_ave,
    output interval_t              rr_post_rr_ave,
    output interval_t              qrs_cur_qrs_ave,
    output amp_t                   r_amp_r_amp_ave,
    output amp_t                   q_amp_q_amp_ave,
    output amp_t                   s_amp_s_amp_ave,
    output amp_t                   p_amp_p_amp_ave,
    output amp_t                   t_amp_t_amp_ave,
    output amp_t                   q_amp_iso,
    output amp_t                   s_amp_iso,
    output amp_t                   t_amp_iso,
    output amp_t                   st_amp_iso,
    output amp_t                   st_slo,
    output feat_sum_t              q_amp_iso_sum,
    output feat_sum_t              s_amp_iso_sum,
    output feat_sum_t              t_amp_iso_sum,
    output feat_sum_t              st_amp_iso_sum,
    output feat_sum_t              st_slo_sum,
    output logic                   feature_done,
    output logic                   init_features_end
);

    logic avg_start;
    logic mi_start;
    logic avg_done;
    logic mi_done;
    logic init_done;
    logic clear_sums;

    feature_sequencer feature_sequencer_i (
        .wclk              (wclk),
        .rst_n             (rst_n),
        .feature_rdy       (feature_rdy),
        .mode              (mode),
        .cnt_lead          (cnt_lead),
        .avg_done          (avg_done),
        .mi_done           (mi_done),
        .avg_start         (avg_start),
        .mi_start          (mi_start),
        .init_done         (init_done),
        .clear_sums        (clear_sums),
        .feature_done      (feature_done),
        .init_features_end (init_features_end)
    );

    beat_average beat_average_i (
        .wclk            (wclk),
        .rst_n           (rst_n),
        .avg_start       (avg_start),
        .init_done       (init_done),
        .rr_pre          (rr_pre),
        .rr_post         (rr_post),
        .q_loc           (q_loc),
        .s_loc           (s_loc),
        .r_amp           (r_amp),
        .q_amp           (q_amp),
        .s_amp           (s_amp),
        .p_amp           (p_amp),
        .t_amp           (t_amp),
        .avg_done        (avg_done),
        .rr_diff         (rr_diff),
        .qrs             (qrs),
        .rr_pre_rr_ave   (rr_pre_rr_ave),
        .rr_post_rr_ave  (rr_post_rr_ave),
        .qrs_cur_qrs_ave (qrs_cur_qrs_ave),
        .r_amp_r_amp_ave (r_amp_r_amp_ave),
        .q_amp_q_amp_ave (q_amp_q_amp_ave),
        .s_amp_s_amp_ave (s_amp_s_amp_ave),
        .p_amp_p_amp_ave (p_amp_p_amp_ave),
        .t_amp_t_amp_ave (t_amp_t_amp_ave)
    );

    st_morphology st_morphology_i (
        .wclk           (wclk),
        .rst_n          (rst_n),
        .mi_start       (mi_start),
        .clear_sums     (clear_sums),
        .q_amp          (q_amp),
        .s_amp          (s_amp),
        .t_amp          (t_amp),
        .st_amp         (st_amp),
        .st_amp_2       (st_amp_2),
        .st_amp_4       (st_amp_4),
        .st_amp_6       (st_amp_6),
        .iso_line       (iso_line),
        .r_loc          (r_loc),
        .t_loc          (t_loc),
        .st_loc         (st_loc),
        .mi_done        (mi_done),
        .q_amp_iso      (q_amp_iso),
        .s_amp_iso      (s_amp_iso),
        .t_amp_iso      (t_amp_iso),
        .st_amp_iso     (st_amp_iso),
        .st_slo         (st_slo),
        .q_amp_iso_sum  (q_amp_iso_sum),
        .s_amp_iso_sum  (s_amp_iso_sum),
        .t_amp_iso_sum  (t_amp_iso_sum),
        .st_amp_iso_sum (st_amp_iso_sum),
        .st_slo_sum     (st_slo_sum)
    );

endmodule

`default_nettype wire

// File: src/st_morphology.sv
`timescale 1ns/1ps
`default_nettype none

`include "feature_defines.svh"

module st_morphology
    import ecg_feature_pkg::*;
(
    input  wire            wclk,
    input  wire            rst_n,
    input  wire            mi_start,
    input  wire            clear_sums,
    input  wire amp_t      q_amp,
    input  wire amp_t      s_amp,
    input  wire amp_t      t_amp,
    input  wire amp_t      st_amp,
    input  wire amp_t      st_amp_2,
    input  wire amp_t      st_amp_4,
    input  wire amp_t      st_amp_6,
    input  wire amp_t      iso_line,
    input  wire interval_t r_loc,
    input  wire interval_t t_loc,
    input  wire interval_t st_loc,
    output logic           mi_done,
    output amp_t           q_amp_iso,
    output amp_t           s_amp_iso,
    output amp_t           t_amp_iso,
    output amp_t           st_amp_iso,
    output amp_t           st_slo,
    output feat_sum_t      q_amp_iso_sum,
    output feat_sum_t      s_amp_iso_sum,
    output feat_sum_t      t_amp_iso_sum,
    output feat_sum_t      st_amp_iso_sum,
    output feat_sum_t      st_slo_sum
);

    // location reported when a wave was not found
    localparam interval_t LOC_NONE = interval_t'(`FEA_LENGTH_IN - 1);

    logic      stage_q;
    interval_t st_t_dist;
    amp_t      q_iso_n;
    amp_t      s_iso_n;
    amp_t      t_iso_n;
    amp_t      st_iso_n;
    amp_t      slo_n;

    function automatic feat_sum_t amp_sub(amp_t a, amp_t b);
        return feat_sum_t'(a) - feat_sum_t'(b);
    endfunction

    // lead 0 restarts the sum
    function automatic feat_sum_t accumulate(amp_t feature, feat_sum_t sum, logic restart);
        feat_sum_t base;
        base = restart ? '0 : sum;
        return base + feat_sum_t'(feature);
    endfunction

    always_ff @(posedge wclk) begin
        if (mi_start) begin
            st_t_dist <= st_loc - t_loc;
        end
    end

    always_comb begin
        q_iso_n  = amp_t'(amp_sub(q_amp, iso_line));
        s_iso_n  = amp_t'(amp_sub(s_amp, iso_line));
        t_iso_n  = amp_t'(amp_sub(t_amp, iso_line));
        st_iso_n = amp_t'(amp_sub(st_amp_2, iso_line));
        // slope step widens with the st to t distance
        if (t_loc == LOC_NONE || r_loc == LOC_NONE) begin
            slo_n = '0;
        end else if (st_t_dist >= 8) begin
            slo_n = amp_t'(amp_sub(st_amp_6, st_amp_2) >>> 2);
        end else if (st_t_dist >= 4) begin
            slo_n = amp_t'(amp_sub(st_amp_4, st_amp_2) >>> 1);
        end else begin
            slo_n = amp_t'(amp_sub(st_amp_2, st_amp));
        end
    end

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q        <= 1'b0;
            mi_done        <= 1'b0;
            q_amp_iso      <= '0;
            s_amp_iso      <= '0;
            t_amp_iso      <= '0;
            st_amp_iso     <= '0;
            st_slo         <= '0;
            q_amp_iso_sum  <= '0;
            s_amp_iso_sum  <= '0;
            t_amp_iso_sum  <= '0;
            st_amp_iso_sum <= '0;
            st_slo_sum     <= '0;
        end else begin
            stage_q <= mi_start;
            mi_done <= stage_q;
            if (stage_q) begin
                q_amp_iso      <= q_iso_n;
                s_amp_iso      <= s_iso_n;
                t_amp_iso      <= t_iso_n;
                st_amp_iso     <= st_iso_n;
                st_slo         <= slo_n;
                q_amp_iso_sum  <= accumulate(q_iso_n, q_amp_iso_sum, clear_sums);
                s_amp_iso_sum  <= accumulate(s_iso_n, s_amp_iso_sum, clear_sums);
                t_amp_iso_sum  <= accumulate(t_iso_n, t_amp_iso_sum, clear_sums);
                st_amp_iso_sum <= accumulate(st_iso_n, st_amp_iso_sum, clear_sums);
                st_slo_sum     <= accumulate(slo_n, st_slo_sum, clear_sums);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/beat_average.sv
`timescale 1ns/1ps
`default_nettype none

`include "feature_defines.svh"

module beat_average
    import ecg_feature_pkg::*;
(
    input  wire            wclk,
    input  wire            rst_n,
    input  wire            avg_start,
    input  wire            init_done,
    input  wire interval_t rr_pre,
    input  wire interval_t rr_post,
    input  wire interval_t q_loc,
    input  wire interval_t s_loc,
    input  wire amp_t      r_amp,
    input  wire amp_t      q_amp,
    input  wire amp_t      s_amp,
    input  wire amp_t      p_amp,
    input  wire amp_t      t_amp,
    output logic           avg_done,
    output interval_t      rr_diff,
    output interval_t      qrs,
    output interval_t      rr_pre_rr_ave,
    output interval_t      rr_post_rr_ave,
    output interval_t      qrs_cur_qrs_ave,
    output amp_t           r_amp_r_amp_ave,
    output amp_t           q_amp_q_amp_ave,
    output amp_t           s_amp_s_amp_ave,
    output amp_t           p_amp_p_amp_ave,
    output amp_t           t_amp_t_amp_ave
);

    logic      stage_q;
    feat_sum_t sum_rr_pre;
    feat_sum_t sum_qrs;
    feat_sum_t sum_r_amp;
    feat_sum_t sum_q_amp;
    feat_sum_t sum_s_amp;
    feat_sum_t sum_p_amp;
    feat_sum_t sum_t_amp;

    // current value against the eight-beat mean
    function automatic feat_sum_t deviation(feat_sum_t cur, feat_sum_t sum);
        return cur - (sum >>> `FEA_AVG_SHIFT);
    endfunction

    // first stage: interval features of this beat
    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q <= 1'b0;
            rr_diff <= '0;
            qrs     <= '0;
        end else begin
            stage_q <= avg_start;
            if (avg_start) begin
                rr_diff <= rr_post - rr_pre;
                qrs     <= s_loc - q_loc;
            end
        end
    end

    // second stage: accumulate, or compare with the frozen average
    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            avg_done        <= 1'b0;
            sum_rr_pre      <= '0;
            sum_qrs         <= '0;
            sum_r_amp       <= '0;
            sum_q_amp       <= '0;
            sum_s_amp       <= '0;
            sum_p_amp       <= '0;
            sum_t_amp       <= '0;
            rr_pre_rr_ave   <= '0;
            rr_post_rr_ave  <= '0;
            qrs_cur_qrs_ave <= '0;
            r_amp_r_amp_ave <= '0;
            q_amp_q_amp_ave <= '0;
            s_amp_s_amp_ave <= '0;
            p_amp_p_amp_ave <= '0;
            t_amp_t_amp_ave <= '0;
        end else begin
            avg_done <= stage_q;
            if (stage_q) begin
                if (init_done) begin
                    rr_pre_rr_ave   <= interval_t'(deviation(feat_sum_t'(rr_pre), sum_rr_pre));
                    // rr_post is measured against the rr_pre mean
                    rr_post_rr_ave  <= interval_t'(deviation(feat_sum_t'(rr_post), sum_rr_pre));
                    qrs_cur_qrs_ave <= interval_t'(deviation(feat_sum_t'(qrs), sum_qrs));
                    r_amp_r_amp_ave <= amp_t'(deviation(feat_sum_t'(r_amp), sum_r_amp));
                    q_amp_q_amp_ave <= amp_t'(deviation(feat_sum_t'(q_amp), sum_q_amp));
                    s_amp_s_amp_ave <= amp_t'(deviation(feat_sum_t'(s_amp), sum_s_amp));
                    p_amp_p_amp_ave <= amp_t'(deviation(feat_sum_t'(p_amp), sum_p_amp));
                    t_amp_t_amp_ave <= amp_t'(deviation(feat_sum_t'(t_amp), sum_t_amp));
                end else begin
                    sum_rr_pre      <= sum_rr_pre + feat_sum_t'(rr_pre);
                    sum_qrs         <= sum_qrs + feat_sum_t'(qrs);
                    sum_r_amp       <= sum_r_amp + feat_sum_t'(r_amp);
                    sum_q_amp       <= sum_q_amp + feat_sum_t'(q_amp);
                    sum_s_amp       <= sum_s_amp + feat_sum_t'(s_amp);
                    sum_p_amp       <= sum_p_amp + feat_sum_t'(p_amp);
                    sum_t_amp       <= sum_t_amp + feat_sum_t'(t_amp);
                    rr_pre_rr_ave   <= '0;
                    rr_post_rr_ave  <= '0;
                    qrs_cur_qrs_ave <= '0;
                    r_amp_r_amp_ave <= '0;
                    q_amp_q_amp_ave <= '0;
                    s_amp_s_amp_ave <= '0;
                    p_amp_p_amp_ave <= '0;
                    t_amp_t_amp_ave <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/feature_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "feature_defines.svh"

module feature_sequencer
    import ecg_feature_pkg::*;
(
    input  wire                    wclk,
    input  wire                    rst_n,
    input  wire                    feature_rdy,
    input  wire                    mode,
    input  wire [`FEA_LEAD_DW-1:0] cnt_lead,
    input  wire                    avg_done,
    input  wire                    mi_done,
    output logic                   avg_start,
    output logic                   mi_start,
    output logic                   init_done,
    output logic                   clear_sums,
    output logic                   feature_done,
    output logic                   init_features_end
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    localparam logic [`FEA_LEAD_DW-1:0] LAST_LEAD  = `FEA_LEAD_DW'(`FEA_NUM_LEADS - 1);
    localparam logic [`FEA_BEAT_DW-1:0] INIT_BEATS = `FEA_BEAT_DW'(`FEA_INIT_BEATS);

    logic [1:0]              state;
    logic                    pend_avg;
    logic                    pend_mi;
    logic [`FEA_BEAT_DW-1:0] beat_cnt;
    logic                    need_avg;
    logic                    need_mi;
    logic                    units_idle;
    logic                    beat_end;

    // averages run once per beat, on lead 0 in multi-lead mode
    assign need_avg   = !mode || (cnt_lead == '0);
    assign need_mi    = mode;
    assign units_idle = !(pend_avg && !avg_done) && !(pend_mi && !mi_done);
    assign beat_end   = (state == ST_DONE) && (!mode || cnt_lead == LAST_LEAD);

    assign clear_sums        = (cnt_lead == '0);
    assign init_done         = (beat_cnt >= INIT_BEATS);
    assign init_features_end = init_done;
    assign feature_done      = (state == ST_DONE);

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            avg_start <= 1'b0;
            mi_start  <= 1'b0;
            pend_avg  <= 1'b0;
            pend_mi   <= 1'b0;
        end else begin
            avg_start <= 1'b0;
            mi_start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (feature_rdy) begin
                        state     <= ST_BUSY;
                        avg_start <= need_avg;
                        mi_start  <= need_mi;
                        pend_avg  <= need_avg;
                        pend_mi   <= need_mi;
                    end
                end
                ST_BUSY: begin
                    if (avg_done) begin
                        pend_avg <= 1'b0;
                    end
                    if (mi_done) begin
                        pend_mi <= 1'b0;
                    end
                    if (units_idle) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // saturating beat count
    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (beat_end && beat_cnt < INIT_BEATS) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/ecg_feature_pkg.sv
`default_nettype none

`include "feature_defines.svh"

package ecg_feature_pkg;

    // signed sample amplitude
    typedef logic signed [`FEA_INPUT_DW-1:0] amp_t;

    // fiducial location or interval in samples
    typedef logic signed [`FEA_INTERVAL_DW-1:0] interval_t;

    // wide enough for eight beats or twelve leads
    typedef logic signed [`FEA_SUM_DW-1:0] feat_sum_t;

endpackage

`default_nettype wire

// File: include/feature_defines.svh
`ifndef FEATURE_DEFINES_SVH
`define FEATURE_DEFINES_SVH

// sample and location widths
`define FEA_INPUT_DW     12
`define FEA_LENGTH_IN    256
`define FEA_INTERVAL_DW  9
`define FEA_SUM_DW       16

// running average over the first beats
`define FEA_INIT_BEATS   8
`define FEA_AVG_SHIFT    3

// multi-lead framing
`define FEA_NUM_LEADS    12
`define FEA_LEAD_DW      4
`define FEA_BEAT_DW      4

`endif
